/* src.f */
source/valu_pkg.sv
source/valu_decode.sv
source/elementwise_alu.sv
source/red_ctrl.sv
source/red_sum_acc.sv
source/mask_popc_counter.sv
source/resp_stage.sv
source/valu_top.sv
verification/tb_clkgen.sv
verification/valu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TB_TOP     ?= valu_tb
RTL_TOP    ?= valu_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/valu_tb.sv */
`default_nettype none

module valu_tb;
    import valu_pkg::*;

    localparam int ADDR_W = 32;
    localparam int VL_W = 8;
    localparam int TOTAL_BEATS = 108;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_BEATS;
    localparam logic [5:0] ALU_OPS [9] = '{OP_ADD, OP_SUB, OP_MINU, OP_MIN, OP_MAXU, OP_MAX,
                                           OP_AND, OP_OR, OP_XOR};
    localparam logic [5:0] MINMAX_OPS [4] = '{OP_MINU, OP_MIN, OP_MAXU, OP_MAX};

    typedef struct packed {
        logic              v;
        logic [63:0]       data;
        logic [ADDR_W-1:0] addr;
        logic [VL_W-1:0]   vl;
        logic [7:0]        be;
    } exp_t;

    logic clk, rst;
    logic req_valid, req_start, req_end;
    logic [5:0] req_func_id;
    sew_e req_sew;
    logic [63:0] req_data0, req_data1, resp_data;
    logic [ADDR_W-1:0] req_addr, resp_addr;
    logic [VL_W-1:0] req_vl, resp_vl;
    logic [7:0] req_be, resp_be;
    logic resp_valid;
    exp_t pipe [2]; // [1] is due at the current falling edge
    string cur_test = "none";
    int cycles = 0;

    tb_clkgen clkgen_i (.clk(clk), .rst(rst));

    valu_top #(.ADDR_W(ADDR_W), .VL_W(VL_W)) dut_i (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_func_id(req_func_id),
        .req_sew(req_sew), .req_data0(req_data0), .req_data1(req_data1),
        .req_addr(req_addr), .req_vl(req_vl), .req_be(req_be), .req_start(req_start),
        .req_end(req_end), .resp_valid(resp_valid), .resp_data(resp_data),
        .resp_addr(resp_addr), .resp_vl(resp_vl), .resp_be(resp_be)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [63:0] lane_mask(input logic [1:0] sew);
        return (sew == 2'd3) ? '1 : ((64'd1 << (8 << sew)) - 64'd1);
    endfunction

    // reference lane model with signed compare by flipped sign bits
    function automatic logic [63:0] model_alu(input logic [5:0] func, input logic [1:0] sew,
                                               input logic [63:0] a, input logic [63:0] b);
        int w;
        logic [63:0] mask, sign, x, y, r, res;
        w = 8 << sew;
        mask = lane_mask(sew);
        sign = 64'd1 << (w - 1);
        res = '0;
        for (int l = 0; l < 64 / w; l++) begin
            x = (a >> (l * w)) & mask;
            y = (b >> (l * w)) & mask;
            case (func)
                OP_ADD:  r = x + y;
                OP_SUB:  r = x - y;
                OP_MINU: r = (x < y) ? x : y;
                OP_MIN:  r = ((x ^ sign) < (y ^ sign)) ? x : y;
                OP_MAXU: r = (x < y) ? y : x;
                OP_MAX:  r = ((x ^ sign) < (y ^ sign)) ? y : x;
                OP_AND:  r = x & y;
                OP_OR:   r = x | y;
                OP_XOR:  r = x ^ y;
                default: r = '0;
            endcase
            res = res | ((r & mask) << (l * w));
        end
        return res;
    endfunction

    function automatic logic [63:0] beat_sum(input logic [1:0] sew, input logic [63:0] d,
                                             input logic [7:0] be);
        int w;
        logic [63:0] s;
        w = 8 << sew;
        s = '0;
        for (int l = 0; l < 64 / w; l++) begin
            if (be[l * w / 8]) begin
                s = s + ((d >> (l * w)) & lane_mask(sew));
            end
        end
        return s & lane_mask(sew);
    endfunction

    function automatic int count_bits(input logic [7:0] be);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (be[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: %s expected %h actual %h", cur_test, what, expected, actual);
            $display("TB FAILED");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_response();
        check_value("resp_valid", 64'(pipe[1].v), 64'(resp_valid));
        if (pipe[1].v) begin
            check_value("resp_data", pipe[1].data, resp_data);
            check_value("resp_addr", 64'(pipe[1].addr), 64'(resp_addr));
            check_value("resp_vl", 64'(pipe[1].vl), 64'(resp_vl));
            check_value("resp_be", 64'(pipe[1].be), 64'(resp_be));
        end
    endtask

    // check what is due and drive the next beat on one falling edge
    task automatic send_beat(input logic v, input logic [5:0] func, input logic [1:0] sew,
                             input logic [63:0] d0, input logic [63:0] d1,
                             input logic [7:0] be, input logic start, input logic last,
                             input logic exp_v, input logic [63:0] exp_d);
        exp_t e;
        @(negedge clk);
        check_response();
        req_valid = v;
        req_func_id = func;
        req_sew = sew_e'(sew);
        req_data0 = d0;
        req_data1 = d1;
        req_addr = $urandom;
        req_vl = 8'($urandom);
        req_be = be;
        req_start = start;
        req_end = last;
        e.v = exp_v;
        e.data = exp_d;
        e.addr = req_addr;
        e.vl = req_vl;
        e.be = be;
        pipe[1] = pipe[0];
        pipe[0] = e;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) send_beat(1'b0, OP_ADD, SEW_8, '0, '0, '0, 1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic alu_beat(input logic [5:0] func, input logic [1:0] sew,
                            input logic [63:0] d0, input logic [63:0] d1);
        send_beat(1'b1, func, sew, d0, d1, 8'($urandom), 1'b0, 1'b0, 1'b1,
                  model_alu(func, sew, d0, d1));
    endtask

    task automatic test_elementwise();
        cur_test = "elementwise";
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 9; i++) begin
                alu_beat(ALU_OPS[i], s[1:0], {$urandom, $urandom}, {$urandom, $urandom});
            end
            alu_beat(OP_ADD, s[1:0], '1, 64'h0101_0101_0101_0101); // every lane wraps
        end
        idle_cycles(3);
    endtask

    task automatic test_min_max();
        logic [63:0] a [3];
        logic [63:0] b [3];
        cur_test = "min_max";
        a[0] = 64'h807F_FF01_0081_7EFE;
        b[0] = 64'h7F80_01FF_FF7E_8100;
        a[1] = 64'h7FFF_FFFF_8000_0000;
        b[1] = 64'h8000_0000_FFFF_FFFF;
        a[2] = {$urandom, $urandom};
        b[2] = {$urandom, $urandom};
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 4; i++) begin
                alu_beat(MINMAX_OPS[i], SEW_8, a[k], b[k]);
                alu_beat(MINMAX_OPS[i], SEW_32, a[k], b[k]);
            end
        end
        idle_cycles(3);
    endtask

    task automatic test_back_to_back();
        cur_test = "back_to_back";
        for (int i = 0; i < 8; i++) begin
            alu_beat(ALU_OPS[$urandom % 9], 2'($urandom), {$urandom, $urandom},
                     {$urandom, $urandom});
        end
        idle_cycles(3);
    endtask

    task automatic sum_group(input logic [1:0] sew, input int beats);
        logic [63:0] d;
        logic [7:0] be;
        logic [63:0] acc;
        logic last;
        acc = '0;
        for (int i = 0; i < beats; i++) begin
            d = {$urandom, $urandom};
            be = (8'($urandom) & 8'hB7) | 8'h01; // some lanes always off
            last = (i == beats - 1);
            acc = (acc + beat_sum(sew, d, be)) & lane_mask(sew);
            send_beat(1'b1, OP_REDSUM, sew, d, '0, be, i == 0, last, last, acc);
        end
    endtask

    task automatic test_sum_reduction();
        cur_test = "sum_reduction";
        sum_group(SEW_16, 4);
        sum_group(SEW_8, 4);
        sum_group(SEW_32, 1); // start and end on one beat
        sum_group(SEW_64, 1);
        idle_cycles(3);
    endtask

    task automatic test_mask_popc();
        logic [7:0] be;
        int total;
        cur_test = "mask_popc";
        total = 0;
        for (int i = 0; i < 3; i++) begin
            be = 8'($urandom);
            total += count_bits(be);
            send_beat(1'b1, OP_POPC, SEW_8, {$urandom, $urandom}, '0, be, i == 0, i == 2,
                      i == 2, 64'(total));
        end
        idle_cycles(3);
        cur_test = "illegal_func";
        send_beat(1'b1, 6'b111111, SEW_8, '1, '1, 8'hFF, 1'b1, 1'b1, 1'b0, '0);
        send_beat(1'b1, 6'b000010, SEW_32, '1, '1, 8'hFF, 1'b1, 1'b1, 1'b0, '0);
        idle_cycles(3);
    endtask

    initial begin
        void'($urandom(22));
        req_valid = 1'b1; // valid add beat held during reset must not answer
        req_func_id = '0;
        req_sew = SEW_8;
        req_data0 = '0;
        req_data1 = '0;
        req_addr = '0;
        req_vl = '0;
        req_be = '0;
        req_start = 1'b0;
        req_end = 1'b0;
        for (int i = 0; i < 2; i++) begin
            pipe[i] = '0;
        end
        wait (rst == 1'b0);
        cur_test = "reset";
        idle_cycles(3); // resp_valid must stay low
        test_elementwise();
        test_min_max();
        test_back_to_back();
        test_sum_reduction();
        test_mask_popc();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* source/valu_top.sv */
`default_nettype none

module valu_top #(
    parameter int ADDR_W = 32,
    parameter int VL_W   = 8
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        req_valid,
    input  wire [valu_pkg::FUNC_W-1:0] req_func_id,
    input  wire valu_pkg::sew_e        req_sew,
    input  wire [valu_pkg::DATA_W-1:0] req_data0,
    input  wire [valu_pkg::DATA_W-1:0] req_data1,
    input  wire [ADDR_W-1:0]           req_addr,
    input  wire [VL_W-1:0]             req_vl,
    input  wire [valu_pkg::BE_W-1:0]   req_be,
    input  wire                        req_start,
    input  wire                        req_end,
    output logic                        resp_valid,
    output logic [valu_pkg::DATA_W-1:0] resp_data,
    output logic [ADDR_W-1:0]           resp_addr,
    output logic [VL_W-1:0]             resp_vl,
    output logic [valu_pkg::BE_W-1:0]   resp_be
);
    import valu_pkg::*;

    valu_op_e          op;
    unit_e             unit;
    logic              red_beat;
    logic              resp_due;
    logic              acc_load;
    logic              acc_en;
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] red_sum;
    logic [DATA_W-1:0] popc_count;

    valu_decode decode_i (
        .req_valid  (req_valid),
        .req_func_id(req_func_id),
        .req_end    (req_end),
        .op         (op),
        .unit       (unit),
        .red_beat   (red_beat),
        .resp_due   (resp_due)
    );

    elementwise_alu alu_i (
        .clk   (clk),
        .rst   (rst),
        .op    (op),
        .sew   (req_sew),
        .data0 (req_data0),
        .data1 (req_data1),
        .result(alu_result)
    );

    red_ctrl red_ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .red_beat(red_beat),
        .start   (req_start),
        .last    (req_end),
        .acc_load(acc_load),
        .acc_en  (acc_en)
    );

    // both accumulators follow the same group control
    red_sum_acc red_sum_i (
        .clk     (clk),
        .rst     (rst),
        .acc_load(acc_load && unit == UNIT_REDSUM),
        .acc_en  (acc_en && unit == UNIT_REDSUM),
        .sew     (req_sew),
        .data0   (req_data0),
        .be      (req_be),
        .sum     (red_sum)
    );

    mask_popc_counter popc_i (
        .clk     (clk),
        .rst     (rst),
        .acc_load(acc_load && unit == UNIT_POPC),
        .acc_en  (acc_en && unit == UNIT_POPC),
        .be      (req_be),
        .count   (popc_count)
    );

    resp_stage #(
        .ADDR_W(ADDR_W),
        .VL_W  (VL_W)
    ) resp_i (
        .clk       (clk),
        .rst       (rst),
        .resp_due  (resp_due),
        .unit      (unit),
        .addr      (req_addr),
        .vl        (req_vl),
        .be        (req_be),
        .alu_result(alu_result),
        .red_sum   (red_sum),
        .popc_count(popc_count),
        .resp_valid(resp_valid),
        .resp_data (resp_data),
        .resp_addr (resp_addr),
        .resp_vl   (resp_vl),
        .resp_be   (resp_be)
    );

endmodule

`default_nettype wire

/* source/resp_stage.sv */
`default_nettype none

module resp_stage #(
    parameter int ADDR_W = 32,
    parameter int VL_W   = 8
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        resp_due,
    input  wire valu_pkg::unit_e       unit,
    input  wire [ADDR_W-1:0]           addr,
    input  wire [VL_W-1:0]             vl,
    input  wire [valu_pkg::BE_W-1:0]   be,
    input  wire [valu_pkg::DATA_W-1:0] alu_result,
    input  wire [valu_pkg::DATA_W-1:0] red_sum,
    input  wire [valu_pkg::DATA_W-1:0] popc_count,
    output logic                        resp_valid,
    output logic [valu_pkg::DATA_W-1:0] resp_data,
    output logic [ADDR_W-1:0]           resp_addr,
    output logic [VL_W-1:0]             resp_vl,
    output logic [valu_pkg::BE_W-1:0]   resp_be
);
    import valu_pkg::*;

    // aligned with the unit result registers
    logic              due_q;
    unit_e             unit_q;
    logic [ADDR_W-1:0] addr_q;
    logic [VL_W-1:0]   vl_q;
    logic [BE_W-1:0]   be_q;
    logic [DATA_W-1:0] sel_data;

    always_comb begin
        case (unit_q)
            UNIT_ALU:    sel_data = alu_result;
            UNIT_REDSUM: sel_data = red_sum;
            UNIT_POPC:   sel_data = popc_count;
            default:     sel_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            due_q      <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            due_q      <= resp_due;
            resp_valid <= due_q;
        end
    end

    always_ff @(posedge clk) begin
        unit_q    <= unit;
        addr_q    <= addr;
        vl_q      <= vl;
        be_q      <= be;
        resp_data <= sel_data;
        resp_addr <= addr_q;
        resp_vl   <= vl_q;
        resp_be   <= be_q;
    end

endmodule

`default_nettype wire

/* source/mask_popc_counter.sv */
`default_nettype none

module mask_popc_counter (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        acc_load,
    input  wire                        acc_en,
    input  wire [valu_pkg::BE_W-1:0]   be,
    output logic [valu_pkg::DATA_W-1:0] count
);
    import valu_pkg::*;

    localparam int POPC_W = $clog2(BE_W + 1);

    logic [POPC_W-1:0] popc;

    assign popc = POPC_W'($countones(be));

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (acc_load) begin
            count <= DATA_W'(popc);
        end else if (acc_en) begin
            count <= count + DATA_W'(popc);
        end
    end

endmodule

`default_nettype wire

/* source/red_sum_acc.sv */
`default_nettype none

module red_sum_acc (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        acc_load,
    input  wire                        acc_en,
    input  wire valu_pkg::sew_e        sew,
    input  wire [valu_pkg::DATA_W-1:0] data0,
    input  wire [valu_pkg::BE_W-1:0]   be,
    output logic [valu_pkg::DATA_W-1:0] sum
);
    import valu_pkg::*;

    logic [DATA_W-1:0] load_val [4];
    logic [DATA_W-1:0] add_val  [4];

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;

        logic [W-1:0] bsum;

        // sum of active elements in this beat, mod 2^W
        always_comb begin
            bsum = '0;
            for (int l = 0; l < DATA_W / W; l++) begin
                if (be[l*W/8]) begin // lowest byte enables the element
                    bsum = bsum + data0[l*W +: W];
                end
            end
        end

        assign load_val[s] = DATA_W'(bsum);
        assign add_val[s]  = DATA_W'(W'(bsum + sum[W-1:0]));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if (acc_load) begin
            sum <= load_val[sew];
        end else if (acc_en) begin
            sum <= add_val[sew]; // upper lanes stay zero
        end
    end

endmodule

`default_nettype wire

/* source/red_ctrl.sv */
`default_nettype none

module red_ctrl (
    input  wire  clk,
    input  wire  rst,
    input  wire  red_beat,
    input  wire  start,
    input  wire  last,
    output logic acc_load,
    output logic acc_en
);

    typedef enum logic {RED_IDLE, RED_ACCUM} red_state_e;

    red_state_e state;

    // start restarts the group even mid-accumulation
    assign acc_load = red_beat && (state == RED_IDLE || start);
    assign acc_en   = red_beat && !acc_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RED_IDLE;
        end else if (red_beat) begin
            if (last) begin
                state <= RED_IDLE;
            end else begin
                state <= RED_ACCUM;
            end
        end
    end

endmodule

`default_nettype wire

/* source/elementwise_alu.sv */
`default_nettype none

module elementwise_alu (
    input  wire                        clk,
    input  wire                        rst,
    input  wire valu_pkg::valu_op_e    op,
    input  wire valu_pkg::sew_e        sew,
    input  wire [valu_pkg::DATA_W-1:0] data0,
    input  wire [valu_pkg::DATA_W-1:0] data1,
    output logic [valu_pkg::DATA_W-1:0] result
);
    import valu_pkg::*;

    // full-beat result for each element width, picked by sew below
    wire [DATA_W-1:0] lane_res [4];

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;

        for (genvar l = 0; l < DATA_W / W; l++) begin : g_lane
            logic [W-1:0] a;
            logic [W-1:0] b;
            logic [W-1:0] r;
            logic         lt_u;
            logic         lt_s;

            assign a    = data0[l*W +: W];
            assign b    = data1[l*W +: W];
            assign lt_u = a < b;
            assign lt_s = $signed(a) < $signed(b);

            always_comb begin
                case (op)
                    OP_ADD:  r = a + b; // wraps within the lane
                    OP_SUB:  r = a - b;
                    OP_MINU: r = lt_u ? a : b;
                    OP_MIN:  r = lt_s ? a : b;
                    OP_MAXU: r = lt_u ? b : a;
                    OP_MAX:  r = lt_s ? b : a;
                    OP_AND:  r = a & b;
                    OP_OR:   r = a | b;
                    OP_XOR:  r = a ^ b;
                    default: r = '0;
                endcase
            end

            assign lane_res[s][l*W +: W] = r;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= lane_res[sew];
        end
    end

endmodule

`default_nettype wire

/* source/valu_decode.sv */
`default_nettype none

module valu_decode (
    input  wire                        req_valid,
    input  wire [valu_pkg::FUNC_W-1:0] req_func_id,
    input  wire                        req_end,
    output valu_pkg::valu_op_e         op,
    output valu_pkg::unit_e            unit,
    output logic                       red_beat,
    output logic                       resp_due
);
    import valu_pkg::*;

    always_comb begin
        op   = OP_ADD; // don't care when unit is none
        unit = UNIT_NONE;
        case (valu_op_e'(req_func_id))
            OP_ADD, OP_SUB, OP_MINU, OP_MIN, OP_MAXU, OP_MAX,
            OP_AND, OP_OR, OP_XOR: begin
                op   = valu_op_e'(req_func_id);
                unit = UNIT_ALU;
            end
            OP_REDSUM: begin
                op   = OP_REDSUM;
                unit = UNIT_REDSUM;
            end
            OP_POPC: begin
                op   = OP_POPC;
                unit = UNIT_POPC;
            end
            default: ; // illegal id, nothing answers
        endcase
    end

    assign red_beat = req_valid && (unit == UNIT_REDSUM || unit == UNIT_POPC);

    // reductions answer only on the closing beat
    assign resp_due = (req_valid && unit == UNIT_ALU) || (red_beat && req_end);

endmodule

`default_nettype wire

/* source/valu_pkg.sv */
`default_nettype none

package valu_pkg;

    localparam int DATA_W = 64;
    localparam int FUNC_W = 6;
    localparam int BE_W   = DATA_W / 8; // one enable per byte

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    // bit 0 of min/max selects signed compare
    typedef enum logic [FUNC_W-1:0] {
        OP_ADD    = 6'b000000,
        OP_SUB    = 6'b000001,
        OP_MINU   = 6'b000100,
        OP_MIN    = 6'b000101,
        OP_MAXU   = 6'b000110,
        OP_MAX    = 6'b000111,
        OP_AND    = 6'b001000,
        OP_OR     = 6'b001001,
        OP_XOR    = 6'b001010,
        OP_REDSUM = 6'b010000,
        OP_POPC   = 6'b010010
    } valu_op_e;

    typedef enum logic [1:0] {UNIT_ALU, UNIT_REDSUM, UNIT_POPC, UNIT_NONE} unit_e;

endpackage

`default_nettype wire
